// File: files.f
src/dcache_pkg.sv
src/lookup_if.sv
src/beat_counter.sv
src/tag_store.sv
src/data_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
bench/dcache_assert.sv
bench/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - src/dcache_pkg.sv
      - src/lookup_if.sv
      - src/beat_counter.sv
      - src/tag_store.sv
      - src/data_store.sv
      - src/dcache_ctrl.sv
      - src/dcache_top.sv
  - target: test
    files:
      - bench/dcache_assert.sv
      - bench/tb_dcache.sv

// File: bench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_SETS = 16;
	localparam int NUM_TESTS = 20;
	localparam int MEM_WORDS = 2 ** 14;	// word addresses below 16'h4000
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;
	localparam logic RD = 1'b0;
	localparam logic WR = 1'b1;

	typedef struct packed {
		logic is_write;
		logic [15:0] addr;
		logic [31:0] wdata;
		logic [3:0] be;
		logic exp_hit;
		logic exp_wb;	// dirty victim goes out first
		logic [15:0] victim;
	} test_t;

	logic clk_50m = 1'b0;
	logic rst_n;
	logic req, wr, ack, mem_req, mem_ack;
	logic [15:0] addr, mem_addr, cur_victim;
	logic [31:0] wdata, rdata, mem_wdata, mem_rdata;
	logic [3:0] be;
	dcache_pkg::mem_op_e mem_op;

	logic [31:0] lcg_state = 32'hac07;
	logic [31:0] mem_model [MEM_WORDS];	// memory behind the port
	logic [31:0] ref_mem [MEM_WORDS];	// what the processor should see
	test_t tests [NUM_TESTS];
	int checks = 0;
	int errors = 0;
	int rd_beats, wr_beats;

	dcache_top #(.NUM_SETS(NUM_SETS)) i_dcache_top (
		.clk_50m(clk_50m), .rst_n(rst_n),
		.req(req), .wr(wr), .addr(addr), .wdata(wdata), .be(be),
		.ack(ack), .rdata(rdata),
		.mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	always #(CLK_PERIOD / 2) clk_50m = ~clk_50m;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// set 0 is 16'h0x0x, set 3 is 16'hxx3x
	task automatic load_table();
		tests[0] = {RD, 16'h0104, 32'h0, 4'h0, 1'b0, 1'b0, 16'h0};
		tests[1] = {RD, 16'h0104, 32'h0, 4'h0, 1'b1, 1'b0, 16'h0};
		tests[2] = {WR, 16'h0108, 32'ha5a5_5a5a, 4'b0101, 1'b1, 1'b0, 16'h0};
		tests[3] = {RD, 16'h0108, 32'h0, 4'h0, 1'b1, 1'b0, 16'h0};
		tests[4] = {RD, 16'h0200, 32'h0, 4'h0, 1'b0, 1'b0, 16'h0};	// second way
		tests[5] = {RD, 16'h0104, 32'h0, 4'h0, 1'b1, 1'b0, 16'h0};	// touch tag 01
		tests[6] = {RD, 16'h0300, 32'h0, 4'h0, 1'b0, 1'b0, 16'h0};	// evicts tag 02
		tests[7] = {RD, 16'h0304, 32'h0, 4'h0, 1'b1, 1'b0, 16'h0};
		tests[8] = {RD, 16'h0200, 32'h0, 4'h0, 1'b0, 1'b1, 16'h0100};
		tests[9] = {RD, 16'h0108, 32'h0, 4'h0, 1'b0, 1'b0, 16'h0};
		tests[10] = {WR, 16'h0f3c, 32'h1234_5678, 4'b1000, 1'b0, 1'b0, 16'h0};
		tests[11] = {RD, 16'h0f3c, 32'h0, 4'h0, 1'b1, 1'b0, 16'h0};
		tests[12] = {RD, 16'h7ff0, 32'h0, 4'h0, 1'b0, 1'b0, 16'h0};
		tests[13] = {WR, 16'h0200, 32'hc3c3_c3c3, 4'b0011, 1'b1, 1'b0, 16'h0};
		tests[14] = {RD, 16'h1030, 32'h0, 4'h0, 1'b0, 1'b0, 16'h0};
		tests[15] = {RD, 16'h1130, 32'h0, 4'h0, 1'b0, 1'b1, 16'h0f30};
		tests[16] = {RD, 16'h0f3c, 32'h0, 4'h0, 1'b0, 1'b0, 16'h0};
		tests[17] = {RD, 16'h0400, 32'h0, 4'h0, 1'b0, 1'b0, 16'h0};
		tests[18] = {RD, 16'h0500, 32'h0, 4'h0, 1'b0, 1'b1, 16'h0200};
		tests[19] = {RD, 16'h0200, 32'h0, 4'h0, 1'b0, 1'b0, 16'h0};
	endtask

	// one processor handshake, then the model update and checks
	task automatic run_test(input int n);
		test_t t;
		int cycles;
		int errs_at_start;
		logic [31:0] got;
		t = tests[n];
		errs_at_start = errors;
		cur_victim = t.victim;
		rd_beats = 0;
		wr_beats = 0;
		req = 1'b1;
		wr = t.is_write;
		addr = t.addr;
		wdata = t.wdata;
		be = t.be;
		cycles = 0;
		do begin
			@(negedge clk_50m);
			cycles++;
		end while (!ack);
		got = rdata;
		req = 1'b0;
		while (ack)
			@(negedge clk_50m);
		if (t.is_write) begin
			for (int b = 0; b < 4; b++) begin
				if (t.be[b])
					ref_mem[t.addr[15:2]][8*b +: 8] = t.wdata[8*b +: 8];
			end
		end else begin
			check("read data", got, ref_mem[t.addr[15:2]]);
		end
		if (t.exp_hit) begin
			check("hit latency", cycles, 2);
			check("fill beats", rd_beats, 0);
		end else begin
			check("fill beats", rd_beats, dcache_pkg::LINE_WORDS);
		end
		check("write-back beats", wr_beats, t.exp_wb ? dcache_pkg::LINE_WORDS : 0);
		$display("test %0d: %s %h %s", n, t.is_write ? "write" : "read", t.addr,
			(errors == errs_at_start) ? "ok" : "failed");
	endtask

	// memory side, 0 to 3 cycles before each ack
	always begin : responder
		logic [31:0] r;
		int word;
		@(negedge clk_50m);
		if (mem_req && !mem_ack) begin
			r = lcg_next();
			repeat (r[17:16]) @(negedge clk_50m);
			word = mem_addr[13:0];
			if (mem_op == dcache_pkg::MEM_WRITE) begin
				check("write-back address", mem_addr, cur_victim[15:2] + wr_beats);
				check("write-back data", mem_wdata, ref_mem[word]);
				mem_model[word] = mem_wdata;
				wr_beats++;
			end else begin
				check("fill address", mem_addr, {2'b00, addr[15:4], rd_beats[1:0]});
				mem_rdata = mem_model[word];
				rd_beats++;
			end
			mem_ack = 1'b1;
			do
				@(negedge clk_50m);
			while (mem_req);
			mem_ack = 1'b0;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_50m);
		$display("timeout: the table did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

	initial begin : main
		int total;
		rst_n = 1'b0;
		req = 1'b0;
		wr = 1'b0;
		addr = '0;
		wdata = '0;
		be = '0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		cur_victim = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_model[i] = lcg_next() ^ (i * 32'h0001_0001);
			ref_mem[i] = mem_model[i];
		end
		load_table();
		repeat (5) @(negedge clk_50m);
		rst_n = 1'b1;
		@(negedge clk_50m);
		check("ack after reset", ack, 1'b0);
		check("mem_req after reset", mem_req, 1'b0);
		for (int n = 0; n < NUM_TESTS; n++)
			run_test(n);
		total = errors + i_dcache_top.i_dcache_assert.fails;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			NUM_TESTS, checks, errors, i_dcache_top.i_dcache_assert.fails);
		if (total == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: bench/dcache_assert.sv
`timescale 1ns/1ps

module dcache_assert (
	input	logic			clk_50m,
	input	logic			rst_n,
	input	logic			req,
	input	logic			wr,
	input	logic [dcache_pkg::ADDR_W-1:0]	addr,
	input	logic [dcache_pkg::WORD_W-1:0]	wdata,
	input	logic [dcache_pkg::BE_W-1:0]	be,
	input	logic			ack,
	input	logic			mem_req,
	input	logic			mem_ack
);

	int fails = 0;	// read by the testbench at the end

	ack_needs_req: assert property (@(posedge clk_50m) disable iff (!rst_n)
		!req && !ack |=> !ack)
	else begin
		$error("ack rose while req was low");
		fails++;
	end

	mem_req_held: assert property (@(posedge clk_50m) disable iff (!rst_n)
		mem_req && !mem_ack |=> mem_req)
	else begin
		$error("mem_req dropped before mem_ack");
		fails++;
	end

	// fields may only move once req is down
	req_fields_stable: assert property (@(posedge clk_50m) disable iff (!rst_n)
		req |=> !req || $stable({wr, addr, wdata, be}))
	else begin
		$error("request fields changed while req was high");
		fails++;
	end

endmodule

bind dcache_top dcache_assert i_dcache_assert (
	.clk_50m(clk_50m), .rst_n(rst_n),
	.req(req), .wr(wr), .addr(addr), .wdata(wdata), .be(be),
	.ack(ack), .mem_req(mem_req), .mem_ack(mem_ack)
);

// File: src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
	parameter int NUM_SETS = 16
) (
	input	logic			clk_50m,
	input	logic			rst_n,

	// processor port
	input	logic			req,
	input	logic			wr,
	input	logic [dcache_pkg::ADDR_W-1:0]	addr,
	input	logic [dcache_pkg::WORD_W-1:0]	wdata,
	input	logic [dcache_pkg::BE_W-1:0]	be,
	output	logic			ack,
	output	logic [dcache_pkg::WORD_W-1:0]	rdata,

	// memory port, word addressed
	output	logic			mem_req,
	output	dcache_pkg::mem_op_e	mem_op,
	output	logic [dcache_pkg::ADDR_W-1:0]	mem_addr,
	output	logic [dcache_pkg::WORD_W-1:0]	mem_wdata,
	input	logic			mem_ack,
	input	logic [dcache_pkg::WORD_W-1:0]	mem_rdata
);

	localparam int IDX_W = $clog2(NUM_SETS);
	localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFF_W - 2;

	logic [TAG_W-1:0] tag, line_tag;
	logic [IDX_W-1:0] index;
	logic [dcache_pkg::OFF_W-1:0] offset, count, data_offset;
	logic beat_done, beat_last;
	logic tag_upd, fill_way, data_we, data_sel_fill, data_way;
	logic [dcache_pkg::WORD_W-1:0] store_word;

	lookup_if #(.NUM_SETS(NUM_SETS)) lk ();

	// addr[1:0] is the byte within the word
	assign offset = addr[2 +: dcache_pkg::OFF_W];
	assign index = addr[2 + dcache_pkg::OFF_W +: IDX_W];
	assign tag = addr[dcache_pkg::ADDR_W-1 -: TAG_W];

	// transfers walk the victim or fill way by beat
	assign data_way = data_sel_fill ? fill_way : lk.hit_way;
	assign data_offset = data_sel_fill ? count : offset;

	assign line_tag = (mem_op == dcache_pkg::MEM_WRITE) ? lk.victim_tag : tag;
	assign mem_addr = {2'b00, line_tag, index, count};
	assign mem_wdata = store_word;
	assign rdata = store_word;

	dcache_ctrl #(.NUM_SETS(NUM_SETS)) i_dcache_ctrl (
		.clk_50m(clk_50m), .rst_n(rst_n),
		.req(req), .wr(wr), .ack(ack),
		.mem_req(mem_req), .mem_op(mem_op), .mem_ack(mem_ack),
		.lk(lk.ctrl),
		.beat_done(beat_done), .beat_last(beat_last),
		.tag_upd(tag_upd), .fill_way(fill_way),
		.data_we(data_we), .data_sel_fill(data_sel_fill)
	);

	beat_counter i_beat_counter (
		.clk_50m(clk_50m), .rst_n(rst_n),
		.beat_done(beat_done), .clear(!data_sel_fill),
		.count(count), .last(beat_last)
	);

	// lru and dirty follow the response while ack is high
	tag_store #(.NUM_SETS(NUM_SETS)) i_tag_store (
		.clk_50m(clk_50m), .rst_n(rst_n),
		.index(index), .tag(tag), .lk(lk.store),
		.tag_upd(tag_upd), .fill_way(fill_way),
		.wr(wr), .hit_upd(ack)
	);

	data_store #(.NUM_SETS(NUM_SETS)) i_data_store (
		.clk_50m(clk_50m),
		.index(index), .way(data_way), .offset(data_offset),
		.be(be), .wdata(wdata), .fill_data(mem_rdata),
		.fill_sel(data_sel_fill), .we(data_we),
		.rdata(store_word)
	);

endmodule

// File: src/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
	parameter int NUM_SETS = 16
) (
	input	logic			clk_50m,
	input	logic			rst_n,

	// processor handshake
	input	logic			req,
	input	logic			wr,
	output	logic			ack,

	// memory handshake
	output	logic			mem_req,
	output	dcache_pkg::mem_op_e	mem_op,
	input	logic			mem_ack,

	lookup_if.ctrl			lk,

	// beat counter
	output	logic			beat_done,
	input	logic			beat_last,

	// store control
	output	logic			tag_upd,
	output	logic			fill_way,
	output	logic			data_we,
	output	logic			data_sel_fill
);

	dcache_pkg::ctrl_state_e state, state_nx;

	// index split needs a power of two
	if ((NUM_SETS < 1) || ((NUM_SETS & (NUM_SETS - 1)) != 0)) begin : g_sets_check
		$error("NUM_SETS must be a power of two");
	end

	always_comb begin
		state_nx = state;
		case (state)
			dcache_pkg::IDLE: begin
				if (req)
					state_nx = dcache_pkg::LOOKUP;
			end
			dcache_pkg::LOOKUP: begin
				if (lk.hit)
					state_nx = dcache_pkg::RESPOND;
				else if (lk.victim_dirty)
					state_nx = dcache_pkg::WRITEBACK;
				else
					state_nx = dcache_pkg::FILL;
			end
			dcache_pkg::WRITEBACK: begin
				if (beat_done && beat_last)
					state_nx = dcache_pkg::FILL;
			end
			dcache_pkg::FILL: begin
				if (beat_done && beat_last)
					state_nx = dcache_pkg::REFILL;
			end
			dcache_pkg::REFILL: begin
				state_nx = dcache_pkg::RESPOND;	// set now holds the new line
			end
			dcache_pkg::RESPOND: begin
				if (!req)
					state_nx = dcache_pkg::IDLE;
			end
			default: begin
				state_nx = dcache_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n)
			state <= dcache_pkg::IDLE;
		else
			state <= state_nx;
	end

	// victim way is fixed for the whole miss
	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n)
			fill_way <= 1'b0;
		else if (state == dcache_pkg::LOOKUP && !lk.hit)
			fill_way <= lk.victim_way;
	end

	// one four-phase beat per word
	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			mem_req <= 1'b0;
		end else if (data_sel_fill) begin
			if (beat_done)
				mem_req <= 1'b0;
			else if (!mem_req && !mem_ack)	// previous beat fully closed
				mem_req <= 1'b1;
		end else begin
			mem_req <= 1'b0;
		end
	end

	assign beat_done = mem_req && mem_ack;
	assign data_sel_fill = (state == dcache_pkg::WRITEBACK) || (state == dcache_pkg::FILL);
	assign mem_op = (state == dcache_pkg::WRITEBACK) ? dcache_pkg::MEM_WRITE
		: dcache_pkg::MEM_READ;

	// tags are written with the last fill word
	assign tag_upd = (state == dcache_pkg::FILL) && beat_done && beat_last;
	assign data_we = ((state == dcache_pkg::FILL) && beat_done)
		|| ((state == dcache_pkg::RESPOND) && wr);

	assign ack = (state == dcache_pkg::RESPOND);

endmodule

// File: src/data_store.sv
`timescale 1ns/1ps

module data_store #(
	parameter int NUM_SETS = 16
) (
	input	logic			clk_50m,
	input	logic [$clog2(NUM_SETS)-1:0]	index,
	input	logic			way,
	input	logic [dcache_pkg::OFF_W-1:0]	offset,
	input	logic [dcache_pkg::BE_W-1:0]	be,
	input	logic [dcache_pkg::WORD_W-1:0]	wdata,
	input	logic [dcache_pkg::WORD_W-1:0]	fill_data,
	input	logic			fill_sel,
	input	logic			we,
	output	logic [dcache_pkg::WORD_W-1:0]	rdata
);

	localparam int IDX_W = $clog2(NUM_SETS);
	localparam int WADDR_W = 1 + IDX_W + dcache_pkg::OFF_W;
	localparam int DEPTH = 2 * NUM_SETS * dcache_pkg::LINE_WORDS;

	logic [dcache_pkg::WORD_W-1:0] mem [DEPTH];
	logic [WADDR_W-1:0] waddr;

	// way, then set, then word in line
	assign waddr = {way, index, offset};

	always_ff @(posedge clk_50m) begin
		if (we) begin
			if (fill_sel) begin
				mem[waddr] <= fill_data;
			end else begin
				for (int b = 0; b < dcache_pkg::BE_W; b++) begin
					if (be[b])
						mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

	assign rdata = mem[waddr];	// also the write-back word

endmodule

// File: src/tag_store.sv
`timescale 1ns/1ps

module tag_store #(
	parameter int NUM_SETS = 16
) (
	input	logic			clk_50m,
	input	logic			rst_n,
	input	logic [$clog2(NUM_SETS)-1:0]	index,
	input	logic [dcache_pkg::ADDR_W-$clog2(NUM_SETS)-dcache_pkg::OFF_W-3:0]	tag,

	lookup_if.store			lk,

	input	logic			tag_upd,
	input	logic			fill_way,
	input	logic			wr,
	input	logic			hit_upd
);

	localparam int IDX_W = $clog2(NUM_SETS);
	localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFF_W - 2;

	logic [NUM_SETS-1:0][1:0] valid;
	logic [NUM_SETS-1:0][1:0] dirty;
	logic [NUM_SETS-1:0] lru;	// way to replace next
	logic [TAG_W-1:0] tags [NUM_SETS][2];

	logic hit0, hit1;

	assign hit0 = valid[index][0] && (tags[index][0] == tag);
	assign hit1 = valid[index][1] && (tags[index][1] == tag);

	assign lk.hit = hit0 || hit1;
	assign lk.hit_way = hit1;
	assign lk.lru_way = lru[index];

	always_comb begin
		if (!valid[index][0])
			lk.victim_way = 1'b0;
		else if (!valid[index][1])
			lk.victim_way = 1'b1;
		else
			lk.victim_way = lk.lru_way;
	end

	assign lk.victim_dirty = valid[index][lk.victim_way] && dirty[index][lk.victim_way];
	assign lk.victim_tag = tags[index][lk.victim_way];

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else if (tag_upd) begin
			// new line comes in clean
			valid[index][fill_way] <= 1'b1;
			dirty[index][fill_way] <= 1'b0;
		end else if (hit_upd && lk.hit) begin
			lru[index] <= ~lk.hit_way;
			if (wr)
				dirty[index][lk.hit_way] <= 1'b1;
		end
	end

	always_ff @(posedge clk_50m) begin
		if (tag_upd)
			tags[index][fill_way] <= tag;
	end

endmodule

// File: src/beat_counter.sv
`timescale 1ns/1ps

module beat_counter (
	input	logic			clk_50m,
	input	logic			rst_n,
	input	logic			beat_done,
	input	logic			clear,
	output	logic [dcache_pkg::OFF_W-1:0]	count,
	output	logic			last
);

	localparam int LAST_BEAT = dcache_pkg::LINE_WORDS - 1;

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (beat_done) begin
			if (last)
				count <= '0;	// ready for the next line
			else
				count <= count + 1'b1;
		end
	end

	assign last = (count == LAST_BEAT[dcache_pkg::OFF_W-1:0]);

endmodule

// File: src/lookup_if.sv
`timescale 1ns/1ps

interface lookup_if #(
	parameter int NUM_SETS = 16
);

	localparam int IDX_W = $clog2(NUM_SETS);
	// byte offset, word offset and index come off the top of the address
	localparam int TAG_W = dcache_pkg::ADDR_W - IDX_W - dcache_pkg::OFF_W - 2;

	logic hit;
	logic hit_way;
	logic victim_way;	// invalid way first, else lru
	logic victim_dirty;
	logic [TAG_W-1:0] victim_tag;
	logic lru_way;

	modport store (
		output hit, hit_way, victim_way, victim_dirty, victim_tag, lru_way
	);

	modport ctrl (
		input hit, hit_way, victim_way, victim_dirty, victim_tag, lru_way
	);

endinterface

// File: src/dcache_pkg.sv
package dcache_pkg;

	// processor side
	localparam int ADDR_W = 16;	// byte address
	localparam int WORD_W = 32;
	localparam int BE_W = WORD_W / 8;

	// line geometry
	localparam int LINE_WORDS = 4;
	localparam int OFF_W = $clog2(LINE_WORDS);	// word offset in a line

	// controller sequence
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		FILL,
		REFILL,
		RESPOND
	} ctrl_state_e;

	// one word per memory handshake
	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_op_e;

endpackage
